//--- rtl/unpack_types_pkg.sv
package unpack_types_pkg;

   // packed input word and the widest sample it may carry
   localparam int unsigned WORD_W   = 32;
   localparam int unsigned SAMPLE_W = 16;

   // width field has to hold SAMPLE_W itself
   localparam int unsigned WIDTH_W = $clog2(SAMPLE_W + 1);
   // count field has to hold WORD_W (width 1 case)
   localparam int unsigned COUNT_W = $clog2(WORD_W + 1);

   // one packed input word
   typedef logic [WORD_W-1:0] word_t;

   // one sample, zero-extended to the full output width
   typedef logic [SAMPLE_W-1:0] sample_t;

   typedef logic [WIDTH_W-1:0] width_t;   // bits per sample, 1..SAMPLE_W
   typedef logic [COUNT_W-1:0] count_t;   // samples left in a word

endpackage

//--- rtl/unpack_fsm_pkg.sv
package unpack_fsm_pkg;

   typedef enum logic [1:0] {
      IDLE,      // waiting for an input word
      OFFER,     // word held, lane req up
      RELEASE,   // waiting for lane ack to fall
      DONE       // input side still finishing
   } dist_state_e;

   typedef enum logic [1:0] {
      EMPTY,
      PRESENT,   // sample req raised or about to be
      WAIT_DROP
   } lane_state_e;

   typedef enum logic [1:0] {
      WAIT_LANE,
      OUT_REQ,
      OUT_DROP,
      LANE_ACK
   } coll_state_e;

endpackage

//--- rtl/word_distributor.sv
`timescale 1ns/1ps

module word_distributor #(
   parameter int N_LANES = 4
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     word_req_i,
   output logic                     word_ack_o,
   input  unpack_types_pkg::word_t  word_i,
   input  unpack_types_pkg::width_t word_width_i,
   output logic [N_LANES-1:0]       lane_word_req_o,
   input  logic [N_LANES-1:0]       lane_word_ack_i,
   output unpack_types_pkg::word_t  lane_word_o [N_LANES],
   output unpack_types_pkg::width_t lane_width_o [N_LANES]
);

   import unpack_types_pkg::*;
   import unpack_fsm_pkg::*;

   localparam int PTR_W = $clog2(N_LANES);

   dist_state_e      state;
   logic [PTR_W-1:0] ptr;
   logic             lane_req;
   logic             lane_idle;
   logic             take;
   word_t            hold_word;
   width_t           hold_width;

   assign lane_idle = !lane_req && !lane_word_ack_i[ptr];
   assign take      = (state == IDLE) && word_req_i && !word_ack_o && lane_idle;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= IDLE;
         ptr        <= '0;
         lane_req   <= 1'b0;
         word_ack_o <= 1'b0;
      end else begin
         // input four-phase finishes on its own once the word is held
         if (word_ack_o && !word_req_i) begin
            word_ack_o <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (take) begin
                  word_ack_o <= 1'b1;
                  state      <= OFFER;
               end
            end
            OFFER: begin
               if (!lane_req) begin
                  lane_req <= 1'b1;   // one cycle after capture
               end else if (lane_word_ack_i[ptr]) begin
                  lane_req <= 1'b0;
                  state    <= RELEASE;
               end
            end
            RELEASE: begin
               if (!lane_word_ack_i[ptr]) begin
                  ptr   <= (ptr == PTR_W'(N_LANES - 1)) ? '0 : ptr + 1'b1;
                  state <= DONE;
               end
            end
            DONE: begin
               if (!word_ack_o) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         hold_word  <= word_i;
         hold_width <= word_width_i;
      end
   end

   // only the pointed slot carries anything
   always_comb begin
      for (int i = 0; i < N_LANES; i++) begin
         lane_word_req_o[i] = lane_req && (ptr == PTR_W'(i));
         lane_word_o[i]     = (ptr == PTR_W'(i)) ? hold_word : '0;
         lane_width_o[i]    = (ptr == PTR_W'(i)) ? hold_width : '0;
      end
   end

   req_held_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      $fell(word_req_i) |-> word_ack_o
   ) else $error("word_req_i fell before word_ack_o rose");

endmodule

//--- rtl/unpack_lane.sv
`timescale 1ns/1ps

module unpack_lane (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      word_req_i,
   output logic                      word_ack_o,
   input  unpack_types_pkg::word_t   word_i,
   input  unpack_types_pkg::width_t  width_i,
   output logic                      smp_req_o,
   input  logic                      smp_ack_i,
   output unpack_types_pkg::sample_t smp_o,
   output logic                      smp_last_o
);

   import unpack_types_pkg::*;
   import unpack_fsm_pkg::*;

   lane_state_e state;
   word_t       shreg;
   width_t      width_q;
   count_t      cnt;
   count_t      cnt_init;
   sample_t     mask;
   logic        take;
   logic        step;

   assign take = (state == EMPTY) && word_req_i && !word_ack_o;
   assign step = (state == WAIT_DROP) && !smp_ack_i;   // sample handshake done

   // whole samples per word, leftover high bits never emitted
   assign cnt_init = (width_i == '0) ? '0 : count_t'(WORD_W / width_i);

   // low width_q bits, full mask at width 16
   assign mask       = ~(sample_t'('1) << width_q);
   assign smp_o      = shreg[SAMPLE_W-1:0] & mask;
   assign smp_last_o = (cnt == count_t'(1));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= EMPTY;
         word_ack_o <= 1'b0;
         smp_req_o  <= 1'b0;
         cnt        <= '0;
      end else begin
         if (word_ack_o && !word_req_i) begin
            word_ack_o <= 1'b0;
         end
         case (state)
            EMPTY: begin
               if (take) begin
                  word_ack_o <= 1'b1;
                  cnt        <= cnt_init;
                  state      <= PRESENT;
               end
            end
            PRESENT: begin
               if (!smp_req_o && !smp_ack_i) begin
                  smp_req_o <= 1'b1;
               end else if (smp_req_o && smp_ack_i) begin
                  smp_req_o <= 1'b0;
                  state     <= WAIT_DROP;
               end
            end
            WAIT_DROP: begin
               if (step) begin
                  cnt   <= cnt - 1'b1;
                  state <= smp_last_o ? EMPTY : PRESENT;
               end
            end
            default: state <= EMPTY;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         shreg   <= word_i;
         width_q <= width_i;
      end else if (step) begin
         shreg <= shreg >> width_q;   // next sample into the low bits
      end
   end

   // width came from the distributor with the word
   width_ok_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      smp_req_o |-> (width_q != '0) && (width_q <= width_t'(SAMPLE_W))
   ) else $error("lane holds a word with width %0d", width_q);

endmodule

//--- rtl/sample_collector.sv
`timescale 1ns/1ps

module sample_collector #(
   parameter int N_LANES = 4
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic [N_LANES-1:0]        lane_smp_req_i,
   output logic [N_LANES-1:0]        lane_smp_ack_o,
   input  unpack_types_pkg::sample_t lane_smp_i [N_LANES],
   input  logic [N_LANES-1:0]        lane_smp_last_i,
   output logic                      sample_req_o,
   input  logic                      sample_ack_i,
   output unpack_types_pkg::sample_t sample_o,
   output logic                      sample_last_o
);

   import unpack_types_pkg::*;
   import unpack_fsm_pkg::*;

   localparam int PTR_W = $clog2(N_LANES);

   coll_state_e      state;
   logic [PTR_W-1:0] ptr;
   logic             lane_ack;
   logic             take;

   assign take = (state == WAIT_LANE) && lane_smp_req_i[ptr];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state        <= WAIT_LANE;
         ptr          <= '0;
         lane_ack     <= 1'b0;
         sample_req_o <= 1'b0;
      end else begin
         case (state)
            WAIT_LANE: begin
               if (take) begin
                  sample_req_o <= 1'b1;
                  state        <= OUT_REQ;
               end
            end
            OUT_REQ: begin
               if (sample_ack_i) begin
                  sample_req_o <= 1'b0;
                  state        <= OUT_DROP;
               end
            end
            OUT_DROP: begin
               // output side closed so release the lane
               if (!sample_ack_i) begin
                  lane_ack <= 1'b1;
                  state    <= LANE_ACK;
               end
            end
            LANE_ACK: begin
               if (!lane_smp_req_i[ptr]) begin
                  lane_ack <= 1'b0;
                  if (sample_last_o) begin   // word done so on to the next lane
                     ptr <= (ptr == PTR_W'(N_LANES - 1)) ? '0 : ptr + 1'b1;
                  end
                  state <= WAIT_LANE;
               end
            end
            default: state <= WAIT_LANE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         sample_o      <= lane_smp_i[ptr];
         sample_last_o <= lane_smp_last_i[ptr];
      end
   end

   always_comb begin
      for (int i = 0; i < N_LANES; i++) begin
         lane_smp_ack_o[i] = lane_ack && (ptr == PTR_W'(i));
      end
   end

   // lane data held from its req rise until our ack rise
   lane_stable_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (lane_smp_req_i[ptr] && !lane_ack) |=> $stable(lane_smp_i[ptr])
   ) else $error("lane sample changed before the collector acked it");

endmodule

//--- rtl/stream_unpack_top.sv
`timescale 1ns/1ps

module stream_unpack_top #(
   parameter int N_LANES = 4
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      word_req_i,
   output logic                      word_ack_o,
   input  unpack_types_pkg::word_t   word_i,
   input  unpack_types_pkg::width_t  word_width_i,
   output logic                      sample_req_o,
   input  logic                      sample_ack_i,
   output unpack_types_pkg::sample_t sample_o,
   output logic                      sample_last_o
);

   import unpack_types_pkg::*;

   // distributor to lanes
   logic [N_LANES-1:0] lane_word_req;
   logic [N_LANES-1:0] lane_word_ack;
   word_t              lane_word [N_LANES];
   width_t             lane_width [N_LANES];

   // lanes to collector
   logic [N_LANES-1:0] lane_smp_req;
   logic [N_LANES-1:0] lane_smp_ack;
   sample_t            lane_smp [N_LANES];
   logic [N_LANES-1:0] lane_smp_last;

   word_distributor #(
      .N_LANES(N_LANES)
   ) dist_i (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .word_req_i     (word_req_i),
      .word_ack_o     (word_ack_o),
      .word_i         (word_i),
      .word_width_i   (word_width_i),
      .lane_word_req_o(lane_word_req),
      .lane_word_ack_i(lane_word_ack),
      .lane_word_o    (lane_word),
      .lane_width_o   (lane_width)
   );

   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      unpack_lane lane_i (
         .clk_i     (clk_i),
         .arst_n_i  (arst_n_i),
         .word_req_i(lane_word_req[g]),
         .word_ack_o(lane_word_ack[g]),
         .word_i    (lane_word[g]),
         .width_i   (lane_width[g]),
         .smp_req_o (lane_smp_req[g]),
         .smp_ack_i (lane_smp_ack[g]),
         .smp_o     (lane_smp[g]),
         .smp_last_o(lane_smp_last[g])
      );
   end

   sample_collector #(
      .N_LANES(N_LANES)
   ) coll_i (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .lane_smp_req_i (lane_smp_req),
      .lane_smp_ack_o (lane_smp_ack),
      .lane_smp_i     (lane_smp),
      .lane_smp_last_i(lane_smp_last),
      .sample_req_o   (sample_req_o),
      .sample_ack_i   (sample_ack_i),
      .sample_o       (sample_o),
      .sample_last_o  (sample_last_o)
   );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 5,
   parameter int RESET_CYCLES   = 10
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);   // release away from the active edge
      arst_n_o = 1'b1;
   end

endmodule

//--- dv/tb_stream_unpack.sv
`timescale 1ns/1ps

module tb_stream_unpack;

   import unpack_types_pkg::*;

   localparam int N_LANES     = 4;
   localparam int CYCLE_LIMIT = 200 * 32 * 40;

   logic    clk;
   logic    arst_n;
   logic    word_req_i;
   logic    word_ack_o;
   word_t   word_i;
   width_t  word_width_i;
   logic    sample_req_o;
   logic    sample_ack_i;
   sample_t sample_o;
   logic    sample_last_o;

   // {last, sample} per expected output
   logic [SAMPLE_W:0] exp_q [$];

   int          errors       = 0;
   int          words_sent   = 0;
   int          accepted     = 0;
   int          pushed       = 0;
   int          received     = 0;
   int          cycles       = 0;
   int          ack_delay_bw = 2;   // bits drawn for the consumer delay
   logic [31:0] prod_lfsr    = 32'h15e;
   logic [31:0] cons_lfsr    = 32'h15e;

   tb_clk_gen #(
      .HALF_PERIOD_NS(5),
      .RESET_CYCLES  (10)
   ) clk_gen_i (
      .clk_o   (clk),
      .arst_n_o(arst_n)
   );

   stream_unpack_top #(
      .N_LANES(N_LANES)
   ) dut_i (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .word_req_i   (word_req_i),
      .word_ack_o   (word_ack_o),
      .word_i       (word_i),
      .word_width_i (word_width_i),
      .sample_req_o (sample_req_o),
      .sample_ack_i (sample_ack_i),
      .sample_o     (sample_o),
      .sample_last_o(sample_last_o)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         st = lfsr_next(st);
         v  = {v[30:0], st[0]};
      end
   endtask

   // zero-extended sample idx of a word taken lsb first
   function automatic sample_t ref_sample(word_t w, int width, int idx);
      sample_t s;
      s = '0;
      for (int b = 0; b < width; b++) begin
         s[b] = w[idx * width + b];
      end
      return s;
   endfunction

   task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR @ %0t ns: %s mismatch, got 0x%0h expected 0x%0h",
                  $time, what, got, exp);
      end
   endtask

   task automatic queue_expected(word_t w, int width);
      int cnt;
      cnt = WORD_W / width;   // leftover high bits dropped
      for (int i = 0; i < cnt; i++) begin
         exp_q.push_back({(i == cnt - 1), ref_sample(w, width, i)});
         pushed++;
      end
   endtask

   task automatic send_word(word_t w, int width);
      logic [31:0] gap;
      queue_expected(w, width);
      word_i       = w;
      word_width_i = width_t'(width);
      word_req_i   = 1'b1;
      do @(negedge clk); while (!word_ack_o);
      word_req_i = 1'b0;
      do @(negedge clk); while (word_ack_o);
      words_sent++;
      draw_bits(prod_lfsr, 2, gap);
      repeat (gap) @(negedge clk);
   endtask

   task automatic send_random(int n_words, bit rand_width, int width);
      logic [31:0] w;
      logic [31:0] wd;
      for (int k = 0; k < n_words; k++) begin
         draw_bits(prod_lfsr, 32, w);
         if (rand_width) begin
            draw_bits(prod_lfsr, 4, wd);
            send_word(w, wd + 1);
         end else begin
            send_word(w, width);
         end
      end
   endtask

   initial begin
      word_req_i   = 1'b0;
      word_i       = '0;
      word_width_i = '0;
      sample_ack_i = 1'b0;
   end

   // output side consumer
   initial begin
      logic [31:0] delay;
      forever begin
         @(negedge clk);
         if (sample_req_o && !sample_ack_i) begin
            draw_bits(cons_lfsr, ack_delay_bw, delay);
            repeat (delay) @(negedge clk);
            sample_ack_i = 1'b1;
            do @(negedge clk); while (sample_req_o);
            sample_ack_i = 1'b0;
         end
      end
   end

   // sample data is held up to the ack rise
   initial begin
      logic [SAMPLE_W:0] exp;
      forever begin
         @(posedge sample_ack_i);
         received++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("output sample 0x%0h arrived at %0t ns with no sample expected",
                     sample_o, $time);
         end else begin
            exp = exp_q.pop_front();
            check_value("sample", sample_o, exp[SAMPLE_W-1:0]);
            check_value("last flag", sample_last_o, exp[SAMPLE_W]);
         end
      end
   end

   initial begin
      forever begin
         @(posedge word_ack_o);
         accepted++;
      end
   end

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the DUT stopped moving data", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      @(posedge arst_n);
      // idle outputs before any input
      repeat (5) begin
         @(negedge clk);
         check_value("word_ack_o after reset", word_ack_o, 0);
         check_value("sample_req_o after reset", sample_req_o, 0);
      end

      send_random(8, 1'b0, 8);

      send_word(32'hA5A5_0F0F, 1);
      send_random(1, 1'b0, 1);
      send_word(32'h1234_ABCD, 16);
      send_random(1, 1'b0, 16);
      send_word(32'hFFFF_FFFF, 5);
      send_word(32'hC000_0001, 5);   // only the dropped bits set above sample 0

      send_random(150, 1'b1, 0);

      ack_delay_bw = 5;   // long stalls on sample_ack_i
      send_random(30, 1'b1, 0);

      // drain until the DUT has handed out as many samples as were expected
      while (received < pushed || sample_req_o || sample_ack_i) begin
         @(negedge clk);
      end
      repeat (20) @(negedge clk);

      check_value("accepted words", accepted, words_sent);
      check_value("expected samples left", exp_q.size(), 0);
      check_value("samples received", received, pushed);

      $display("errors %0d, words sent %0d, samples received %0d, cycles %0d",
               errors, words_sent, received, cycles);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- src.f
rtl/unpack_types_pkg.sv
rtl/unpack_fsm_pkg.sv
rtl/word_distributor.sv
rtl/unpack_lane.sv
rtl/sample_collector.sv
rtl/stream_unpack_top.sv
dv/tb_clk_gen.sv
dv/tb_stream_unpack.sv

//--- Bender.yml
package:
  name: stream_unpack

sources:
  # packages first, then the design
  - files:
      - rtl/unpack_types_pkg.sv
      - rtl/unpack_fsm_pkg.sv
      - rtl/word_distributor.sv
      - rtl/unpack_lane.sv
      - rtl/sample_collector.sv
      - rtl/stream_unpack_top.sv

  # testbench
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_stream_unpack.sv
